//--- IssueScheduler.f
+incdir+design
design/SchedulerTypes.sv
design/ReadyBitTable.sv
design/ProducerMatrix.sv
design/WakeupLogic.sv
design/IssueSelect.sv
design/IssueScheduler.sv
test/IssueScheduler_props.sv
test/IssueSchedulerTb.sv

//--- design/IssueScheduler.sv
//////////////////////////////////////////////////
// Issue scheduler top level.
// Wakeup logic feeding the issue selector.
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "scheduler_settings.svh"

module IssueScheduler (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic dispatch,
    input  SchedulerTypes::DispatchOp [`SCHED_DISPATCH_WIDTH-1:0] dispatchOp,
    input  SchedulerTypes::EntryIndex [`SCHED_DISPATCH_WIDTH-1:0] writePtr,
    input  logic wakeup,
    input  SchedulerTypes::WakeupIn wakeupIn,
    input  SchedulerTypes::EntryVector notIssued,
    output SchedulerTypes::IssueGrant grant
);

    // Per-entry readiness from the matrix.
    SchedulerTypes::EntryVector opReady;

    WakeupLogic wakeupLogic (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .dispatch(dispatch),
        .dispatchOp(dispatchOp),
        .writePtr(writePtr),
        .wakeup(wakeup),
        .wakeupIn(wakeupIn),
        .notIssued(notIssued),
        .opReady(opReady)
    );

    IssueSelect issueSelect (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .opReady(opReady),
        .notIssued(notIssued),
        .grant(grant)
    );

endmodule

//--- design/IssueSelect.sv
//////////////////////////////////////////////////
// Issue select.
// Registered lowest-index grant among ready,
// not yet issued entries.
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "scheduler_settings.svh"

module IssueSelect (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  SchedulerTypes::EntryVector opReady,
    input  SchedulerTypes::EntryVector notIssued,
    output SchedulerTypes::IssueGrant grant
);

    SchedulerTypes::EntryVector candidate;
    SchedulerTypes::IssueGrant pick;

    assign candidate = opReady & notIssued;

    // Scan downward so the lowest index is assigned last.
    always_comb begin
        pick = '0;
        for (int e = `SCHED_ENTRY_NUM - 1; e >= 0; e--) begin
            if (candidate[e]) begin
                pick.valid = 1'b1;
                pick.index = SchedulerTypes::EntryIndex'(e);
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            grant <= '0;
        end else if (!stall) begin
            grant <= pick;
        end
    end

endmodule

//--- design/ProducerMatrix.sv
//////////////////////////////////////////////////
// Producer matrix.
// One dependency row per queue entry, written on
// dispatch and cleared column-wise by wakeup.
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "scheduler_settings.svh"

module ProducerMatrix (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic dispatch,
    input  SchedulerTypes::EntryIndex [`SCHED_DISPATCH_WIDTH-1:0] writePtr,
    input  SchedulerTypes::EntryIndex [`SCHED_DISPATCH_WIDTH-1:0][`SCHED_SRC_NUM-1:0] srcPtr,
    input  logic [`SCHED_DISPATCH_WIDTH-1:0][`SCHED_SRC_NUM-1:0] srcReady,
    input  SchedulerTypes::EntryVector [`SCHED_DISPATCH_WIDTH-1:0] dependStore,
    input  SchedulerTypes::EntryVector
        [`SCHED_WAKEUP_WIDTH+`SCHED_STORE_ISSUE_WIDTH-1:0] wakeupVector,
    output SchedulerTypes::EntryVector opReady
);

    SchedulerTypes::EntryVector [`SCHED_ENTRY_NUM-1:0] rowReg;
    SchedulerTypes::EntryVector [`SCHED_ENTRY_NUM-1:0] rowNext;
    SchedulerTypes::EntryVector [`SCHED_DISPATCH_WIDTH-1:0] dispatchRow;
    SchedulerTypes::EntryVector clearMask;

    // Columns released this cycle.
    always_comb begin
        clearMask = '0;
        for (int w = 0; w < `SCHED_WAKEUP_WIDTH + `SCHED_STORE_ISSUE_WIDTH; w++) begin
            clearMask = clearMask | wakeupVector[w];
        end
    end

    // New row per lane: unready producers plus older stores.
    always_comb begin
        for (int i = 0; i < `SCHED_DISPATCH_WIDTH; i++) begin
            dispatchRow[i] = dependStore[i];
            for (int j = 0; j < `SCHED_SRC_NUM; j++) begin
                if (!srcReady[i][j]) begin
                    dispatchRow[i][srcPtr[i][j]] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        rowNext = rowReg;
        if (dispatch) begin
            for (int i = 0; i < `SCHED_DISPATCH_WIDTH; i++) begin
                rowNext[writePtr[i]] = dispatchRow[i];
            end
        end
        // Wakeup clears every row, new ones too.
        for (int e = 0; e < `SCHED_ENTRY_NUM; e++) begin
            rowNext[e] = rowNext[e] & ~clearMask;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rowReg <= '0;
        end else if (!stall) begin
            rowReg <= rowNext;
        end
    end

    // Ready once nothing is left to wait on.
    always_comb begin
        for (int e = 0; e < `SCHED_ENTRY_NUM; e++) begin
            opReady[e] = ~|rowReg[e];
        end
    end

endmodule

//--- design/ReadyBitTable.sv
//////////////////////////////////////////////////
// Ready bit table for physical registers.
// Dispatch clears, wakeup sets, lookup bypasses
// the current cycle's wakeup tags.
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "scheduler_settings.svh"

module ReadyBitTable (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic wakeup,
    input  SchedulerTypes::RegTag [`SCHED_WAKEUP_WIDTH-1:0] wakeupTag,
    input  logic dispatch,
    input  SchedulerTypes::DispatchOp [`SCHED_DISPATCH_WIDTH-1:0] dispatchOp,
    output logic [`SCHED_DISPATCH_WIDTH-1:0][`SCHED_SRC_NUM-1:0] srcReady
);

    logic [`SCHED_PREG_NUM-1:0] readyReg;
    logic [`SCHED_PREG_NUM-1:0] readyNext;
    logic [`SCHED_PREG_NUM-1:0] wokenMask;

    // Registers produced in this cycle.
    always_comb begin
        wokenMask = '0;
        if (wakeup) begin
            for (int w = 0; w < `SCHED_WAKEUP_WIDTH; w++) begin
                if (wakeupTag[w].valid) begin
                    wokenMask[wakeupTag[w].num] = 1'b1;
                end
            end
        end
    end

    // Wakeup first, then dispatch so a new destination wins.
    always_comb begin
        readyNext = readyReg | wokenMask;
        if (dispatch) begin
            for (int i = 0; i < `SCHED_DISPATCH_WIDTH; i++) begin
                if (dispatchOp[i].dst.valid) begin
                    readyNext[dispatchOp[i].dst.num] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readyReg <= '1;
        end else if (!stall) begin
            readyReg <= readyNext;
        end
    end

    // Source lookup with wakeup bypass.
    always_comb begin
        for (int i = 0; i < `SCHED_DISPATCH_WIDTH; i++) begin
            for (int j = 0; j < `SCHED_SRC_NUM; j++) begin
                srcReady[i][j] = readyReg[dispatchOp[i].src[j].num]
                               | wokenMask[dispatchOp[i].src[j].num];
            end
        end
    end

endmodule

//--- design/SchedulerTypes.sv
//////////////////////////////////////////////////
// Scheduler types package.
// Register tags, entry types, dispatch and
// wakeup bundles, grant record.
//////////////////////////////////////////////////

`include "scheduler_settings.svh"

package SchedulerTypes;

    // Basic index and mask types.
    typedef logic [$clog2(`SCHED_PREG_NUM)-1:0] PRegNum;
    typedef logic [$clog2(`SCHED_ENTRY_NUM)-1:0] EntryIndex;
    typedef logic [`SCHED_ENTRY_NUM-1:0] EntryVector;

    // Physical register with its valid bit.
    typedef struct packed {
        logic valid;
        PRegNum num;
    } RegTag;

    // One dispatched instruction.
    typedef struct packed {
        RegTag dst;
        RegTag [`SCHED_SRC_NUM-1:0] src;
        EntryIndex [`SCHED_SRC_NUM-1:0] srcPtr;  // producer entry per source
        logic isStore;
        logic isLoad;
        logic memDependPred;
    } DispatchOp;

    // Broadcast from the execution pipeline.
    typedef struct packed {
        RegTag [`SCHED_WAKEUP_WIDTH-1:0] regTag;
        EntryVector [`SCHED_WAKEUP_WIDTH+`SCHED_STORE_ISSUE_WIDTH-1:0] vector;
    } WakeupIn;

    typedef struct packed {
        logic valid;
        EntryIndex index;
    } IssueGrant;

endpackage

//--- design/WakeupLogic.sv
//////////////////////////////////////////////////
// Wakeup logic.
// Ready bit table and producer matrix, plus the
// store bit vector for predicted load ordering.
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "scheduler_settings.svh"

module WakeupLogic (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic dispatch,
    input  SchedulerTypes::DispatchOp [`SCHED_DISPATCH_WIDTH-1:0] dispatchOp,
    input  SchedulerTypes::EntryIndex [`SCHED_DISPATCH_WIDTH-1:0] writePtr,
    input  logic wakeup,
    input  SchedulerTypes::WakeupIn wakeupIn,
    input  SchedulerTypes::EntryVector notIssued,
    output SchedulerTypes::EntryVector opReady
);

    logic [`SCHED_DISPATCH_WIDTH-1:0][`SCHED_SRC_NUM-1:0] tableReady;
    logic [`SCHED_DISPATCH_WIDTH-1:0][`SCHED_SRC_NUM-1:0] srcReady;
    SchedulerTypes::EntryIndex [`SCHED_DISPATCH_WIDTH-1:0][`SCHED_SRC_NUM-1:0] srcPtr;
    SchedulerTypes::EntryVector
        [`SCHED_WAKEUP_WIDTH+`SCHED_STORE_ISSUE_WIDTH-1:0] wakeupVector;
    SchedulerTypes::EntryVector [`SCHED_DISPATCH_WIDTH-1:0] dependStore;
    SchedulerTypes::EntryVector storeVecReg;
    SchedulerTypes::EntryVector storeVecNext;

    ReadyBitTable readyBitTable (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .wakeup(wakeup),
        .wakeupTag(wakeupIn.regTag),
        .dispatch(dispatch),
        .dispatchOp(dispatchOp),
        .srcReady(tableReady)
    );

    // An unused source never waits.
    always_comb begin
        for (int i = 0; i < `SCHED_DISPATCH_WIDTH; i++) begin
            for (int j = 0; j < `SCHED_SRC_NUM; j++) begin
                srcReady[i][j] = tableReady[i][j] | ~dispatchOp[i].src[j].valid;
                srcPtr[i][j] = dispatchOp[i].srcPtr[j];
            end
        end
    end

    // Vectors only count while the wakeup strobe is up.
    always_comb begin
        for (int w = 0; w < `SCHED_WAKEUP_WIDTH + `SCHED_STORE_ISSUE_WIDTH; w++) begin
            wakeupVector[w] = wakeup ? wakeupIn.vector[w] : '0;
        end
    end

    // Lanes in program order, so a load sees stores from lower lanes.
    always_comb begin
        storeVecNext = storeVecReg & notIssued;
        for (int i = 0; i < `SCHED_DISPATCH_WIDTH; i++) begin
            dependStore[i] = '0;
            if (dispatch && dispatchOp[i].isStore) begin
                storeVecNext[writePtr[i]] = 1'b1;
            end else if (dispatchOp[i].isLoad && dispatchOp[i].memDependPred) begin
                dependStore[i] = storeVecNext;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            storeVecReg <= '0;
        end else if (!stall) begin
            storeVecReg <= storeVecNext;
        end
    end

    ProducerMatrix producerMatrix (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .dispatch(dispatch),
        .writePtr(writePtr),
        .srcPtr(srcPtr),
        .srcReady(srcReady),
        .dependStore(dependStore),
        .wakeupVector(wakeupVector),
        .opReady(opReady)
    );

endmodule

//--- design/scheduler_settings.svh
//////////////////////////////////////////////////
// Scheduler sizing macros.
// Lane counts, queue depth and register count.
//////////////////////////////////////////////////

`ifndef SCHEDULER_SETTINGS_SVH
`define SCHEDULER_SETTINGS_SVH

// Instructions written into the queue per cycle.
`define SCHED_DISPATCH_WIDTH 2

// Register wakeup lanes from the execution pipeline.
`define SCHED_WAKEUP_WIDTH 2

// Extra wakeup vector lanes for issued stores.
`define SCHED_STORE_ISSUE_WIDTH 1

// Issue queue depth.
`define SCHED_ENTRY_NUM 8

// Physical register file size.
`define SCHED_PREG_NUM 16

// Source operands per instruction.
`define SCHED_SRC_NUM 2

`endif

//--- run.sh
#!/usr/bin/env bash
# Build and run the issue scheduler testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module IssueSchedulerTb \
    -f IssueScheduler.f -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log

grep -q "tests failed" sim.log \
    && { echo "FAIL"; exit 1; } \
    || { echo "PASS"; exit 0; }

//--- test/IssueSchedulerTb.sv
//////////////////////////////////////////////////
// Testbench for the issue scheduler.
// Clock, reset, file-driven stimulus, checks,
// watchdog and summary.
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "scheduler_settings.svh"

module IssueSchedulerTb;

    logic clk;
    logic rstN;
    logic stall;
    logic dispatch;
    logic wakeup;
    SchedulerTypes::DispatchOp [`SCHED_DISPATCH_WIDTH-1:0] dispatchOp;
    SchedulerTypes::EntryIndex [`SCHED_DISPATCH_WIDTH-1:0] writePtr;
    SchedulerTypes::WakeupIn wakeupIn;
    SchedulerTypes::EntryVector notIssued;
    SchedulerTypes::IssueGrant grant;

    string lines[$];
    int lineCount;
    int errorCount;
    int passCount;
    int failCount;
    bit testBad;
    bit loaded;

    IssueScheduler dut (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .dispatch(dispatch),
        .dispatchOp(dispatchOp),
        .writePtr(writePtr),
        .wakeup(wakeup),
        .wakeupIn(wakeupIn),
        .notIssued(notIssued),
        .grant(grant)
    );

    always #4 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            errorCount++;
            testBad = 1'b1;
        end
    endtask

    // A file tag of 1x names valid register x.
    function automatic SchedulerTypes::DispatchOp buildOp(input logic [7:0] dst,
            input logic [7:0] s1, input logic [7:0] s0, input logic [3:0] p1,
            input logic [3:0] p0, input logic [3:0] flags);
        SchedulerTypes::DispatchOp op;
        op.dst = dst[4:0];
        op.src[1] = s1[4:0];
        op.src[0] = s0[4:0];
        op.srcPtr[1] = p1[2:0];
        op.srcPtr[0] = p0[2:0];
        op.isStore = flags[2];
        op.isLoad = flags[1];
        op.memDependPred = flags[0];
        return op;
    endfunction

    task automatic loadLines();
        int fd;
        string line;
        fd = $fopen("test/issue_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            errorCount++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        lineCount = lines.size();
    endtask

    task automatic reportTest(input int num);
        if (testBad) begin
            failCount++;
            $display("test %0d failed", num);
        end else begin
            passCount++;
            $display("test %0d passed", num);
        end
        testBad = 1'b0;
    endtask

    initial begin
        int n;
        int testNum;
        int curTest;
        logic [3:0] stallF, dispF, wakeF, chkR, chkG, expG;
        logic [7:0] dstF[2], s1F[2], s0F[2];
        logic [3:0] p1F[2], p0F[2], flF[2], wpF[2];
        logic [7:0] t1F, t0F, v2F, v1F, v0F, notIssF, expR;
        clk = 1'b0;
        rstN = 1'b0;
        stall = 1'b0;
        dispatch = 1'b0;
        wakeup = 1'b0;
        dispatchOp = '0;
        writePtr = '0;
        wakeupIn = '0;
        notIssued = '0;
        curTest = 0;
        loadLines();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;
        for (int i = 0; i < lineCount; i++) begin
            n = $sscanf(lines[i],
                "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                testNum, stallF, dispF,
                dstF[0], s1F[0], s0F[0], p1F[0], p0F[0], flF[0],
                dstF[1], s1F[1], s0F[1], p1F[1], p0F[1], flF[1],
                wpF[0], wpF[1], wakeF, t1F, t0F, v2F, v1F, v0F,
                notIssF, expR, chkR, expG, chkG);
            if (n != 28) begin
                $display("stimulus line %0d is malformed", i + 1);
                errorCount++;
                testBad = 1'b1;
            end
            if (i > 0 && testNum != curTest) begin
                reportTest(curTest);
            end
            curTest = testNum;
            stall = stallF[0];
            dispatch = dispF[0];
            dispatchOp[0] = buildOp(dstF[0], s1F[0], s0F[0], p1F[0], p0F[0], flF[0]);
            dispatchOp[1] = buildOp(dstF[1], s1F[1], s0F[1], p1F[1], p0F[1], flF[1]);
            writePtr[0] = wpF[0][2:0];
            writePtr[1] = wpF[1][2:0];
            wakeup = wakeF[0];
            wakeupIn.regTag[1] = t1F[4:0];
            wakeupIn.regTag[0] = t0F[4:0];
            wakeupIn.vector[2] = v2F;
            wakeupIn.vector[1] = v1F;
            wakeupIn.vector[0] = v0F;
            notIssued = notIssF;
            // Sample just before the next rising edge.
            #6;
            if (chkR[0]) begin
                checkValue($sformatf("test%0d opReady", testNum), 32'(expR),
                           32'(dut.opReady));
            end
            if (chkG[0]) begin
                checkValue($sformatf("test%0d grant", testNum), 32'(expG), 32'(grant));
            end
            @(posedge clk);
            #1;
        end
        reportTest(curTest);
        $display("%0d passed, %0d failed, %0d check errors", passCount, failCount, errorCount);
        if (errorCount == 0 && failCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog sized from the number of stimulus lines.
    initial begin
        wait (loaded);
        #((lineCount + 20) * 8);
        $display("timeout: the run did not reach its end in time");
        $display("tests failed");
        $finish;
    end

endmodule

//--- test/IssueScheduler_props.sv
//////////////////////////////////////////////////
// Concurrent assertions for the issue scheduler.
// Reset, grant target and stall hold.
//////////////////////////////////////////////////

`timescale 1ns/1ns

module IssueSchedulerProps (
    input logic clk,
    input logic rstN,
    input logic stall,
    input SchedulerTypes::EntryVector opReady,
    input SchedulerTypes::EntryVector notIssued,
    input SchedulerTypes::IssueGrant grant
);

    SchedulerTypes::EntryVector prevCand;
    logic prevStall;

    // Previous cycle's candidates and stall.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            prevCand <= '0;
            prevStall <= 1'b0;
        end else begin
            prevCand <= opReady & notIssued;
            prevStall <= stall;
        end
    end

    noGrantInReset: assert property (@(posedge clk) !rstN |-> !grant.valid)
        else $error("grant valid during reset");

    grantWasCandidate: assert property (@(posedge clk) disable iff (!rstN)
        grant.valid && !prevStall |-> prevCand[grant.index])
        else $error("grant names an entry that was not a candidate");

    holdUnderStall: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> $stable(grant))
        else $error("grant moved under stall");

endmodule

bind IssueScheduler IssueSchedulerProps props (
    .clk(clk),
    .rstN(rstN),
    .stall(stall),
    .opReady(opReady),
    .notIssued(notIssued),
    .grant(grant)
);

//--- test/issue_testdata.txt
# test stall disp | lane0 dst s1 s0 p1 p0 fl | lane1 dst s1 s0 p1 p0 fl | wp0 wp1 wake
# t1 t0 v2 v1 v0 notIssued expOpReady chkOpReady expGrant chkGrant (hex, tag 1x = valid reg x)
1 0 1 11 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 00 FF 1 0 1
1 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 01 FF 1 0 1
1 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 01 FF 1 8 1
2 0 1 12 00 00 0 0 0 00 00 00 0 0 0 1 0 0 00 00 00 00 00 00 FF 1 8 1
2 0 1 13 00 12 0 1 0 00 00 00 0 0 0 2 0 0 00 00 00 00 00 02 FF 1 0 1
2 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 06 FB 1 9 1
2 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 1 00 12 00 00 02 04 FB 1 9 1
2 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 04 FF 1 0 1
2 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 04 FF 1 A 1
3 0 1 14 00 00 0 0 0 15 00 00 0 0 0 4 5 0 00 00 00 00 00 00 FF 1 A 1
3 0 1 16 15 14 5 4 0 00 00 00 0 0 0 3 0 0 00 00 00 00 00 00 FF 1 0 1
3 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 1 00 14 00 00 10 08 F7 1 0 1
3 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 1 00 15 00 20 00 08 F7 1 0 1
3 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 08 FF 1 0 1
3 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 00 FF 1 B 1
4 0 1 00 00 00 0 0 4 00 00 00 0 0 4 0 6 0 00 00 00 00 00 00 FF 1 0 1
4 0 1 00 00 00 0 0 4 00 00 00 0 0 0 7 0 0 00 00 00 00 00 41 FF 1 0 1
4 0 1 00 00 00 0 0 3 00 00 00 0 0 0 1 0 0 00 00 00 00 00 C0 FF 1 8 1
4 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 C2 FD 1 E 1
4 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 1 00 00 40 00 00 C2 FD 1 E 1
4 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 1 00 00 80 00 00 82 FD 1 E 1
4 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 02 FF 1 F 1
4 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 02 FF 1 9 1
5 0 1 00 00 13 0 2 0 00 00 00 0 0 0 5 0 1 00 13 00 00 00 00 FF 1 9 1
5 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 20 FF 1 0 1
5 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 20 FF 1 D 1
6 0 1 00 00 11 0 0 0 00 00 00 0 0 0 4 0 0 00 00 00 00 00 00 FF 1 D 1
6 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 30 EF 1 0 1
6 1 1 17 00 00 0 0 0 00 00 00 0 0 0 2 0 1 00 11 00 00 01 30 EF 1 D 1
6 1 1 17 00 00 0 0 0 00 00 00 0 0 0 2 0 1 00 11 00 00 01 30 EF 1 D 1
6 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 30 EF 1 D 1
6 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 1 00 11 00 00 01 10 EF 1 D 1
6 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 10 FF 1 0 1
6 0 0 00 00 00 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 00 00 00 FF 1 C 1
